// ==== Makefile ====
# Verilator build and run of the icache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= icache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TEST PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail unless the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/icache.sv ====
`timescale 1ns/10ps

module icache import icache_pkg::*; #(
	parameter int NUM_SETS = 64
) (
	input  logic  clk,
	input  logic  rst,
	input  addr_t addr,
	input  logic  valid,
	input  logic  flush,
	output addr_t mem_addr,
	input  line_t mem_line,
	output inst_t inst,
	output logic  ready,
	output cnt_t  hit_count,
	output cnt_t  miss_count
);

	localparam int INDEX_W = $clog2(NUM_SETS);

	logic [INDEX_W-1:0] index;
	way_vec_t           hit_way;
	way_vec_t           en_way;
	way_vec_t           fill_way;
	logic               fill;
	logic               wr;
	line_t              wr_line;
	line_t              rd_line0;
	line_t              rd_line1;
	line_t              rd_line2;
	line_t              rd_line3;

	// next level always returns a whole aligned line
	assign mem_addr = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	// set index, shared by all four line memories
	assign index = addr[OFFSET_W +: INDEX_W];

	// tags and valid bits, combinational hit
	icache_tag_store #(
		.NUM_SETS (NUM_SETS)
	) tag_store (
		.clk      (clk),
		.rst      (rst),
		.addr     (addr),
		.fill     (fill),
		.fill_way (fill_way),
		.hit_way  (hit_way)
	);

	// line data, one memory per way
	icache_line_ram #(.NUM_SETS(NUM_SETS)) way0 (
		.clk     (clk),
		.en      (en_way[0]),
		.wr      (wr),
		.index   (index),
		.wr_line (wr_line),
		.rd_line (rd_line0)
	);

	icache_line_ram #(.NUM_SETS(NUM_SETS)) way1 (
		.clk     (clk),
		.en      (en_way[1]),
		.wr      (wr),
		.index   (index),
		.wr_line (wr_line),
		.rd_line (rd_line1)
	);

	icache_line_ram #(.NUM_SETS(NUM_SETS)) way2 (
		.clk     (clk),
		.en      (en_way[2]),
		.wr      (wr),
		.index   (index),
		.wr_line (wr_line),
		.rd_line (rd_line2)
	);

	icache_line_ram #(.NUM_SETS(NUM_SETS)) way3 (
		.clk     (clk),
		.en      (en_way[3]),
		.wr      (wr),
		.index   (index),
		.wr_line (wr_line),
		.rd_line (rd_line3)
	);

	// hit or refill decision, victim choice, output pipeline, counters
	icache_ctrl #(
		.NUM_SETS (NUM_SETS)
	) ctrl (
		.clk        (clk),
		.rst        (rst),
		.valid      (valid),
		.flush      (flush),
		.addr       (addr),
		.hit_way    (hit_way),
		.mem_line   (mem_line),
		.rd_line0   (rd_line0),
		.rd_line1   (rd_line1),
		.rd_line2   (rd_line2),
		.rd_line3   (rd_line3),
		.en_way     (en_way),
		.wr         (wr),
		.wr_line    (wr_line),
		.fill       (fill),
		.fill_way   (fill_way),
		.inst       (inst),
		.ready      (ready),
		.hit_count  (hit_count),
		.miss_count (miss_count)
	);

endmodule

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl import icache_pkg::*; #(
	parameter int NUM_SETS = 64
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     valid,
	input  logic     flush,
	input  addr_t    addr,
	input  way_vec_t hit_way,
	input  line_t    mem_line,
	input  line_t    rd_line0,
	input  line_t    rd_line1,
	input  line_t    rd_line2,
	input  line_t    rd_line3,
	output way_vec_t en_way,
	output logic     wr,
	output line_t    wr_line,
	output logic     fill,
	output way_vec_t fill_way,
	output inst_t    inst,
	output logic     ready,
	output cnt_t     hit_count,
	output cnt_t     miss_count
);

	localparam int INDEX_W = $clog2(NUM_SETS);

	// selects one 32-bit word out of the line
	localparam int WORD_SEL_W = OFFSET_W - 2;

	logic [INDEX_W-1:0] index;
	logic               lookup;
	logic               hit;
	logic               miss;
	way_vec_t           victim_cur;

	// round-robin victim pointer per set, one-hot
	way_vec_t victim [NUM_SETS];

	// state carried into the cycle after the lookup
	way_vec_t              hit_way_q;
	line_t                 refill_q;
	logic [WORD_SEL_W-1:0] offset_q;
	line_t                 sel_line;

	assign index = addr[OFFSET_W +: INDEX_W];

	// a flush kills the lookup before it touches anything
	assign lookup = valid && !flush;
	assign hit    = lookup && (hit_way != '0);
	assign miss   = lookup && (hit_way == '0);

	assign victim_cur = victim[index];

	// way enables
	// hit reads only the matching way, miss writes only the victim
	assign en_way = hit ? hit_way : (miss ? victim_cur : '0);

	// refill straight from the next-level line, same cycle
	assign wr      = miss;
	assign wr_line = mem_line;

	// tag store update goes to the same way
	assign fill     = miss;
	assign fill_way = miss ? victim_cur : '0;

	// victim rotates left by one way after each refill of its set
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				victim[s] <= way_vec_t'(1);
			end
		end else if (miss) begin
			victim[index] <= {victim_cur[NUM_WAYS-2:0], victim_cur[NUM_WAYS-1]};
		end
	end

	// one-cycle lookup pipeline
	// hit_way_q of zero means the line comes from refill_q
	always_ff @(posedge clk) begin
		if (rst) begin
			ready     <= 1'b0;
			hit_way_q <= '0;
			refill_q  <= '0;
			offset_q  <= '0;
		end else begin
			ready <= lookup;
			if (lookup) begin
				hit_way_q <= hit_way;
				offset_q  <= addr[OFFSET_W-1:2];
			end else begin
				hit_way_q <= '0;
			end
			// only a miss needs the fetched line kept around
			if (miss) begin
				refill_q <= mem_line;
			end
		end
	end

	// hit and miss statistics, lookups only
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_count  <= '0;
			miss_count <= '0;
		end else begin
			if (hit) begin
				hit_count <= hit_count + 1'b1;
			end
			if (miss) begin
				miss_count <= miss_count + 1'b1;
			end
		end
	end

	// way mux, refill line when no way hit
	always_comb begin
		case (hit_way_q)
			4'b0001: sel_line = rd_line0;
			4'b0010: sel_line = rd_line1;
			4'b0100: sel_line = rd_line2;
			4'b1000: sel_line = rd_line3;
			default: sel_line = refill_q;
		endcase
	end

	// word mux by the registered offset
	assign inst = sel_line[offset_q*INST_W +: INST_W];

endmodule

// ==== hdl/icache_line_ram.sv ====
`timescale 1ns/10ps

module icache_line_ram import icache_pkg::*; #(
	parameter  int NUM_SETS = 64,
	localparam int INDEX_W  = $clog2(NUM_SETS)
) (
	input  logic               clk,
	input  logic               en,
	input  logic               wr,
	input  logic [INDEX_W-1:0] index,
	input  line_t              wr_line,
	output line_t              rd_line
);

	// line storage of one way, one entry per set
	line_t mem [NUM_SETS];

	// single port, one access per cycle
	// a write stores the whole line, no byte enables
	always_ff @(posedge clk) begin
		if (en && wr) begin
			mem[index] <= wr_line;
		end
	end

	// synchronous read, data shows up the cycle after the enable
	// output holds its value while the way is idle or being written
	always_ff @(posedge clk) begin
		if (en && !wr) begin
			rd_line <= mem[index];
		end
	end

endmodule

// ==== hdl/icache_pkg.sv ====
package icache_pkg;

	// fetch address width, full 64-bit pc
	localparam int ADDR_W = 64;

	// one cache line holds four instructions
	localparam int LINE_W = 128;

	// byte offset inside a line, 16 bytes per line
	localparam int OFFSET_W = 4;

	// associativity
	localparam int NUM_WAYS = 4;

	// width of one instruction word
	localparam int INST_W = 32;

	// fetch address as seen by the cache
	typedef logic [ADDR_W-1:0] addr_t;

	// whole line, as stored in a way and as returned by the next level
	typedef logic [LINE_W-1:0] line_t;

	// single instruction selected out of a line
	typedef logic [INST_W-1:0] inst_t;

	// one bit per way
	// one-hot for a hit or a victim, all zero for a miss or no access
	typedef logic [NUM_WAYS-1:0] way_vec_t;

	// event counter for hit and miss statistics
	typedef logic [31:0] cnt_t;

	// the number of sets is not fixed here
	// it is a module parameter, passed down from the top level,
	// and each block derives its index and tag widths from it

endpackage

// ==== hdl/icache_tag_store.sv ====
`timescale 1ns/10ps

module icache_tag_store import icache_pkg::*; #(
	parameter int NUM_SETS = 64
) (
	input  logic     clk,
	input  logic     rst,
	input  addr_t    addr,
	input  logic     fill,
	input  way_vec_t fill_way,
	output way_vec_t hit_way
);

	// address split: | tag | index | byte offset |
	localparam int INDEX_W = $clog2(NUM_SETS);
	localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

	// tag arrays, one per way
	logic [TAG_W-1:0] tags [NUM_WAYS][NUM_SETS];

	// valid bits, one vector per way, bit i belongs to set i
	logic [NUM_SETS-1:0] line_valid [NUM_WAYS];

	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;

	assign index = addr[OFFSET_W +: INDEX_W];
	assign tag   = addr[ADDR_W-1 -: TAG_W];

	// tag write on a refill
	// only the way named by fill_way takes the new tag
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill && fill_way[w]) begin
				tags[w][index] <= tag;
			end
		end
	end

	// valid bits
	// cleared on reset, set by a refill, never cleared otherwise
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				line_valid[w] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill && fill_way[w]) begin
					line_valid[w][index] <= 1'b1;
				end
			end
		end
	end

	// parallel compare of all ways in the indexed set
	// at most one way can match since a refill only happens on a miss
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_way[w] = line_valid[w][index] && (tags[w][index] == tag);
		end
	end

endmodule

// ==== icache.f ====
hdl/icache_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_line_ram.sv
hdl/icache_ctrl.sv
hdl/icache.sv
tb/icache_asserts.sv
tb/tb_icache.sv

// ==== tb/icache_asserts.sv ====
`timescale 1ns/10ps

module icache_asserts import icache_pkg::*; (
	input logic  clk,
	input logic  rst,
	input addr_t addr,
	input logic  valid,
	input logic  flush,
	input addr_t mem_addr,
	input line_t mem_line,
	input inst_t inst,
	input logic  ready,
	input cnt_t  hit_count,
	input cnt_t  miss_count
);

	// count of failed assertions for the testbench result lines
	int unsigned fails = 0;

	logic  lookup;
	addr_t line_base;
	inst_t mem_word;
	inst_t mem_word_q;
	cnt_t  event_total;

	// a lookup is a valid cycle that is not flushed
	assign lookup = valid && !flush;

	// fetch address with the byte offset inside the line masked off
	assign line_base = addr & ~addr_t'(LINE_W/8 - 1);

	// word the memory model returns for the current fetch address
	assign mem_word = mem_line[addr[OFFSET_W-1:2]*INST_W +: INST_W];

	assign event_total = hit_count + miss_count;

	// expected word delayed by one cycle like the cache output
	always_ff @(posedge clk) begin
		mem_word_q <= mem_word;
	end

	// next level is asked for the line that holds the fetch address
	mem_addr_is_line: assert property (@(posedge clk) disable iff (rst)
		mem_addr == line_base)
	else begin
		fails++;
		$error("ERR mem_addr: got %h, expected %h", mem_addr, line_base);
	end

	// ready follows a lookup after one cycle and a flush kills it
	ready_follows_lookup: assert property (@(posedge clk) disable iff (rst)
		ready == $past(lookup))
	else begin
		fails++;
		$error("ready does not follow the lookup of the previous cycle");
	end

	// data of a hit or a refill matches the memory model
	inst_matches_model: assert property (@(posedge clk) disable iff (rst)
		ready |-> inst == mem_word_q)
	else begin
		fails++;
		$error("ERR inst: got %h, expected %h", inst, mem_word_q);
	end

	// every lookup bumps exactly one of the two counters
	lookup_counts_once: assert property (@(posedge clk) disable iff (rst)
		lookup |=> event_total == $past(event_total) + 32'd1)
	else begin
		fails++;
		$error("a lookup did not add exactly one to the counters");
	end

	// idle or flushed cycles leave both counters alone
	idle_counts_none: assert property (@(posedge clk) disable iff (rst)
		!lookup |=> $stable(hit_count) && $stable(miss_count))
	else begin
		fails++;
		$error("a counter moved without a lookup");
	end

	// reset clears ready and the counters
	reset_clears: assert property (@(posedge clk)
		rst |=> !ready && hit_count == '0 && miss_count == '0)
	else begin
		fails++;
		$error("ready or a counter is not zero after reset");
	end

endmodule

// ==== tb/tb_icache.sv ====
`timescale 1ns/10ps

module tb_icache import icache_pkg::*; ();

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY  = 2;
	localparam int NUM_SETS     = 64;
	localparam int INDEX_W      = $clog2(NUM_SETS);
	localparam int NUM_RAND     = 24;
	localparam int NUM_B2B      = 9;
	localparam int NUM_CONFLICT = 5;
	localparam int CONFLICT_SET = 6'h3c;
	localparam int FLUSH_SET    = 6'h2e;

	// rough cycle count of all tests
	// the watchdog allows twice that plus a margin
	localparam int TEST_CYCLES     = 1 + 6 + (2*NUM_RAND + 2) + 11 + 5 + (NUM_B2B + 2);
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2*TEST_CYCLES + 50;

	logic  clk;
	logic  rst;
	addr_t addr;
	logic  valid;
	logic  flush;
	addr_t mem_addr;
	line_t mem_line;
	inst_t inst;
	logic  ready;
	cnt_t  hit_count;
	cnt_t  miss_count;

	// reference tags, valid bits and victim pointers per set
	addr_t tag_m [NUM_SETS][NUM_WAYS];
	logic  vld_m [NUM_SETS][NUM_WAYS];
	int    vic_m [NUM_SETS];

	cnt_t        exp_hits;
	cnt_t        exp_misses;
	cnt_t        hits_before;
	cnt_t        misses_before;
	int          tb_errors;
	int          err_mark;
	int          tests_passed;
	int          tests_failed;
	addr_t       rand_addr [NUM_RAND];
	addr_t       b2b_addr [NUM_B2B];
	addr_t       conflict_addr [NUM_CONFLICT];
	addr_t       flush_addr;

	initial clk = 1'b0;
	always #(CLK_PERIOD/2) clk = ~clk;

	icache #(
		.NUM_SETS (NUM_SETS)
	) dut (
		.clk        (clk),
		.rst        (rst),
		.addr       (addr),
		.valid      (valid),
		.flush      (flush),
		.mem_addr   (mem_addr),
		.mem_line   (mem_line),
		.inst       (inst),
		.ready      (ready),
		.hit_count  (hit_count),
		.miss_count (miss_count)
	);

	bind icache icache_asserts chk (
		.clk        (clk),
		.rst        (rst),
		.addr       (addr),
		.valid      (valid),
		.flush      (flush),
		.mem_addr   (mem_addr),
		.mem_line   (mem_line),
		.inst       (inst),
		.ready      (ready),
		.hit_count  (hit_count),
		.miss_count (miss_count)
	);

	// per-word inversion so the four words of a line differ in more than the low bits
	function automatic inst_t word_mask(int k);
		case (k)
			0: return 32'h0000_0000;
			1: return 32'hffff_0000;
			2: return 32'h0000_ffff;
			default: return 32'hffff_ffff;
		endcase
	endfunction

	// next-level memory model
	// word k is line address bits 31:4 with k appended
	function automatic line_t model_line(addr_t a);
		line_t l;
		for (int k = 0; k < 4; k++) begin
			l[k*32 +: 32] = {a[31:4], 4'(k)} ^ word_mask(k);
		end
		return l;
	endfunction

	// combinational memory that answers in the same cycle
	assign mem_line = model_line(mem_addr);

	function automatic int set_of(addr_t a);
		return int'(a[OFFSET_W +: INDEX_W]);
	endfunction

	function automatic addr_t tag_of(addr_t a);
		return a >> (OFFSET_W + INDEX_W);
	endfunction

	// reference lookup with a rotating victim per set on a miss
	task automatic model_lookup(addr_t a);
		int    s;
		addr_t t;
		logic  hit;
		s = set_of(a);
		t = tag_of(a);
		hit = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (vld_m[s][w] && tag_m[s][w] == t) begin
				hit = 1'b1;
			end
		end
		if (hit) begin
			exp_hits++;
		end else begin
			tag_m[s][vic_m[s]] = t;
			vld_m[s][vic_m[s]] = 1'b1;
			vic_m[s] = (vic_m[s] + 1) % NUM_WAYS;
			exp_misses++;
		end
	endtask

	// one fetch driven just after the edge and sampled at the next one
	task automatic lookup_cycle(addr_t a, logic f);
		@(posedge clk);
		#DRIVE_DELAY;
		addr  = a;
		valid = 1'b1;
		flush = f;
		if (!f) begin
			model_lookup(a);
		end
	endtask

	task automatic idle_cycles(int n);
		repeat (n) begin
			@(posedge clk);
			#DRIVE_DELAY;
			valid = 1'b0;
			flush = 1'b0;
		end
	endtask

	task automatic check_value(string name, cnt_t got, cnt_t exp);
		if (got !== exp) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			tb_errors++;
		end
	endtask

	// own checks plus failed assertions
	function automatic int total_errors();
		return tb_errors + int'(dut.chk.fails);
	endfunction

	task automatic begin_test();
		err_mark      = total_errors();
		hits_before   = hit_count;
		misses_before = miss_count;
	endtask

	// let the last lookup retire and then compare counters with the model
	task automatic settle();
		idle_cycles(2);
		check_value("hit_count", hit_count, exp_hits);
		check_value("miss_count", miss_count, exp_misses);
	endtask

	task automatic report_test(int num, string name);
		if (total_errors() == err_mark) begin
			tests_passed++;
			$display("test %0d %s: passed", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed", num, name);
		end
	endtask

	// hang guard
	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'ha195_3af5));
		rst          = 1'b1;
		addr         = '0;
		valid        = 1'b0;
		flush        = 1'b0;
		exp_hits     = '0;
		exp_misses   = '0;
		tb_errors    = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int s = 0; s < NUM_SETS; s++) begin
			vic_m[s] = 0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				vld_m[s][w] = 1'b0;
				tag_m[s][w] = '0;
			end
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		// test 1 covers the quiet outputs right after reset
		begin_test();
		check_value("ready", cnt_t'(ready), '0);
		check_value("hit_count", hit_count, '0);
		check_value("miss_count", miss_count, '0);
		report_test(1, "reset state");

		// test 2 fetches all words of a cold line with one refill and three hits
		begin_test();
		for (int k = 0; k < 4; k++) begin
			lookup_cycle(64'h0000_0000_0001_2340 + addr_t'(4*k), 1'b0);
		end
		settle();
		check_value("hit_count delta", hit_count - hits_before, 32'd3);
		check_value("miss_count delta", miss_count - misses_before, 32'd1);
		report_test(2, "cold line words");

		// test 3 fetches random lines in the lower half of the sets twice
		begin_test();
		for (int i = 0; i < NUM_RAND; i++) begin
			rand_addr[i] = {$urandom, $urandom};
			rand_addr[i][1:0] = 2'b00;
			rand_addr[i][OFFSET_W+INDEX_W-1] = 1'b0;
		end
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < NUM_RAND; i++) begin
				lookup_cycle(rand_addr[i], 1'b0);
			end
		end
		settle();
		report_test(3, "random refetch");

		// test 4 puts five tags in one untouched set so the fifth takes way 0 again
		begin_test();
		for (int k = 0; k < NUM_CONFLICT; k++) begin
			conflict_addr[k] = 64'h0000_0040_0000_0000 | (addr_t'(k + 1) << 16)
				| (addr_t'(CONFLICT_SET) << OFFSET_W) | addr_t'(4 * (k % 4));
			lookup_cycle(conflict_addr[k], 1'b0);
		end
		lookup_cycle(conflict_addr[0], 1'b0);
		for (int k = 2; k < NUM_CONFLICT; k++) begin
			lookup_cycle(conflict_addr[k], 1'b0);
		end
		settle();
		check_value("hit_count delta", hit_count - hits_before, 32'd3);
		check_value("miss_count delta", miss_count - misses_before, 32'd6);
		report_test(4, "victim rotation");

		// test 5 shows a flushed lookup leaves no trace and the next access misses
		begin_test();
		flush_addr = 64'h0000_0077_0005_0000 | (addr_t'(FLUSH_SET) << OFFSET_W) | 64'h8;
		lookup_cycle(flush_addr, 1'b1);
		idle_cycles(1);
		check_value("ready", cnt_t'(ready), '0);
		check_value("hit_count", hit_count, hits_before);
		check_value("miss_count", miss_count, misses_before);
		lookup_cycle(flush_addr, 1'b0);
		settle();
		check_value("miss_count delta", miss_count - misses_before, 32'd1);
		report_test(5, "flush");

		// test 6 runs one lookup per cycle with hits and refills mixed
		begin_test();
		b2b_addr[0] = 64'h0000_0000_0001_2348;
		b2b_addr[1] = 64'h0000_0000_0001_2340;
		b2b_addr[2] = 64'h0000_0012_0003_0304;
		b2b_addr[3] = 64'h0000_0012_0003_030c;
		b2b_addr[4] = 64'h0000_0012_0003_0300;
		b2b_addr[5] = conflict_addr[3];
		b2b_addr[6] = rand_addr[0];
		b2b_addr[7] = 64'h0000_0034_0006_0318;
		b2b_addr[8] = 64'h0000_0000_0001_2344;
		for (int i = 0; i < NUM_B2B; i++) begin
			lookup_cycle(b2b_addr[i], 1'b0);
		end
		settle();
		report_test(6, "back-to-back");

		$display("summary: %0d tests passed, %0d tests failed, %0d check errors",
			tests_passed, tests_failed, total_errors());
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
